// File: Makefile
TOP = tb_vortex_top

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f all.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -qx "No errors" sim.log

clean:
	rm -rf obj_dir sim.log

// File: all.f
vx_config_pkg.sv
vx_csr_pkg.sv
csr_bus_if.sv
io_req_if.sv
csr_io_router.sv
cluster_csr_unit.sv
io_arbiter.sv
vortex_top.sv
vortex_top_props.sv
tb_vortex_top.sv

// File: cluster_csr_unit.sv
`timescale 1ns/1ps

module cluster_csr_unit #(
    parameter int CLUSTER_ID = 0
) (
    input  logic     clk,
    input  logic     reset,
    csr_bus_if.unit  bus,
    io_req_if.unit   io,
    output logic     busy,
    output logic     ebreak
);

    localparam int AW = vx_config_pkg::CSR_ADDR_WIDTH;

    vx_config_pkg::word_t  scratch [vx_csr_pkg::NUM_SCRATCH];
    vx_config_pkg::word_t  putc_count;
    vx_config_pkg::word_t  read_data;
    logic                  ebreak_flag;
    logic                  is_scratch;
    logic                  is_putc_wr;
    logic                  is_ebreak_wr;
    logic                  req_fire;

    // Scratch block is 4-aligned, so the upper bits pick it out
    assign is_scratch   = (bus.req_addr[AW-1:2] == vx_csr_pkg::CSR_SCRATCH_BASE[AW-1:2]);
    assign is_putc_wr   = bus.req_rw && (bus.req_addr == vx_csr_pkg::CSR_IO_PUTC);
    assign is_ebreak_wr = bus.req_rw && (bus.req_addr == vx_csr_pkg::CSR_EBREAK);

    // A console write waits until the previous one has left
    assign bus.req_ready = !bus.rsp_valid && !(is_putc_wr && io.valid);
    assign req_fire      = bus.req_valid && bus.req_ready;

    always_comb begin
        if (is_scratch) begin
            read_data = scratch[bus.req_addr[1:0]];
        end else begin
            case (bus.req_addr)
                vx_csr_pkg::CSR_CLUSTER_ID: read_data = vx_config_pkg::word_t'(CLUSTER_ID);
                vx_csr_pkg::CSR_IO_PUTC:    read_data = putc_count;
                vx_csr_pkg::CSR_EBREAK:     read_data = {31'b0, ebreak_flag};
                default:                    read_data = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bus.rsp_valid <= 1'b0;
            io.valid      <= 1'b0;
            ebreak_flag   <= 1'b0;
            putc_count    <= '0;
        end else begin
            if (bus.rsp_valid && bus.rsp_ready) begin
                bus.rsp_valid <= 1'b0;
            end else if (req_fire) begin
                bus.rsp_valid <= 1'b1;
            end

            if (io.valid && io.ready) begin
                io.valid <= 1'b0;
            end else if (req_fire && is_putc_wr) begin
                io.valid   <= 1'b1;
                putc_count <= putc_count + 1'b1;
            end

            if (req_fire && is_ebreak_wr) begin
                ebreak_flag <= bus.req_data[0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            // Writes answer with zero
            bus.rsp_data <= bus.req_rw ? '0 : read_data;
        end
        if (req_fire && bus.req_rw && is_scratch) begin
            scratch[bus.req_addr[1:0]] <= bus.req_data;
        end
        if (req_fire && is_putc_wr) begin
            io.data <= bus.req_data;
            // tag is the count before this write
            io.tag  <= putc_count[vx_config_pkg::IO_LOCAL_TAG_WIDTH-1:0];
        end
    end

    assign busy   = io.valid;
    assign ebreak = ebreak_flag;

endmodule

// File: csr_bus_if.sv
`timescale 1ns/1ps

interface csr_bus_if;

    logic                      req_valid;
    vx_config_pkg::csr_addr_t  req_addr;
    logic                      req_rw;
    vx_config_pkg::word_t      req_data;
    logic                      req_ready;

    logic                      rsp_valid;
    vx_config_pkg::word_t      rsp_data;
    logic                      rsp_ready;

    modport router (
        output req_valid, req_addr, req_rw, req_data, rsp_ready,
        input  req_ready, rsp_valid, rsp_data
    );

    modport unit (
        input  req_valid, req_addr, req_rw, req_data, rsp_ready,
        output req_ready, rsp_valid, rsp_data
    );

endinterface

// File: csr_io_router.sv
`timescale 1ns/1ps

module csr_io_router #(
    parameter int NUM_CLUSTERS = 4
) (
    input  logic                             clk,
    input  logic                             reset,

    input  logic                             csr_io_req_valid,
    input  logic [$clog2(NUM_CLUSTERS)-1:0]  csr_io_req_coreid,
    input  vx_config_pkg::csr_addr_t         csr_io_req_addr,
    input  logic                             csr_io_req_rw,
    input  vx_config_pkg::word_t             csr_io_req_data,
    output logic                             csr_io_req_ready,

    output logic                             csr_io_rsp_valid,
    output vx_config_pkg::word_t             csr_io_rsp_data,
    input  logic                             csr_io_rsp_ready,

    csr_bus_if.router                        buses [NUM_CLUSTERS],

    output logic                             busy
);

    localparam int CLUSTER_BITS = $clog2(NUM_CLUSTERS);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_WAIT,
        ST_RSP
    } state_t;

    state_t                    state;
    logic [CLUSTER_BITS-1:0]   sel_q;
    vx_config_pkg::csr_addr_t  addr_q;
    logic                      rw_q;
    vx_config_pkg::word_t      data_q;
    vx_config_pkg::word_t      rsp_data_q;

    logic [NUM_CLUSTERS-1:0]   bus_req_ready;
    logic [NUM_CLUSTERS-1:0]   bus_rsp_valid;
    vx_config_pkg::word_t      bus_rsp_data [NUM_CLUSTERS];

    // Payload goes to every bus, only the selected one sees valid
    for (genvar i = 0; i < NUM_CLUSTERS; i++) begin : g_bus
        assign buses[i].req_valid = (state == ST_REQ) && (sel_q == CLUSTER_BITS'(i));
        assign buses[i].req_addr  = addr_q;
        assign buses[i].req_rw    = rw_q;
        assign buses[i].req_data  = data_q;
        assign buses[i].rsp_ready = (state == ST_WAIT) && (sel_q == CLUSTER_BITS'(i));

        assign bus_req_ready[i] = buses[i].req_ready;
        assign bus_rsp_valid[i] = buses[i].rsp_valid;
        assign bus_rsp_data[i]  = buses[i].rsp_data;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: if (csr_io_req_valid) state <= ST_REQ;
                ST_REQ:  if (bus_req_ready[sel_q]) state <= ST_WAIT;
                ST_WAIT: if (bus_rsp_valid[sel_q]) state <= ST_RSP;
                ST_RSP:  if (csr_io_rsp_ready) state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && csr_io_req_valid) begin
            sel_q  <= csr_io_req_coreid;
            addr_q <= csr_io_req_addr;
            rw_q   <= csr_io_req_rw;
            data_q <= csr_io_req_data;
        end
        if (state == ST_WAIT && bus_rsp_valid[sel_q]) begin
            rsp_data_q <= bus_rsp_data[sel_q];
        end
    end

    assign csr_io_req_ready = (state == ST_IDLE);
    assign csr_io_rsp_valid = (state == ST_RSP);
    assign csr_io_rsp_data  = rsp_data_q;
    assign busy             = (state != ST_IDLE);

endmodule

// File: io_arbiter.sv
`timescale 1ns/1ps

module io_arbiter #(
    parameter int NUM_CLUSTERS = 4
) (
    input  logic                  clk,
    input  logic                  reset,

    io_req_if.arbiter             ins [NUM_CLUSTERS],

    output logic                  io_req_valid,
    output vx_config_pkg::word_t  io_req_data,
    output logic [$clog2(NUM_CLUSTERS)+vx_config_pkg::IO_LOCAL_TAG_WIDTH-1:0] io_req_tag,
    input  logic                  io_req_ready,

    output logic                  busy
);

    localparam int CLUSTER_BITS = $clog2(NUM_CLUSTERS);

    logic [NUM_CLUSTERS-1:0]       in_valid;
    vx_config_pkg::word_t          in_data [NUM_CLUSTERS];
    vx_config_pkg::io_local_tag_t  in_tag [NUM_CLUSTERS];

    logic [CLUSTER_BITS-1:0]       rr_ptr;
    logic [CLUSTER_BITS-1:0]       grant_idx;
    logic                          grant_valid;
    logic                          out_free;

    assign out_free = !io_req_valid || io_req_ready;

    for (genvar i = 0; i < NUM_CLUSTERS; i++) begin : g_in
        assign in_valid[i] = ins[i].valid;
        assign in_data[i]  = ins[i].data;
        assign in_tag[i]   = ins[i].tag;
        assign ins[i].ready = out_free && grant_valid && (grant_idx == CLUSTER_BITS'(i));
    end

    // Search starts at the pointer and wraps
    always_comb begin
        logic [CLUSTER_BITS-1:0] cand;
        grant_valid = 1'b0;
        grant_idx   = rr_ptr;
        for (int k = 0; k < NUM_CLUSTERS; k++) begin
            cand = rr_ptr + CLUSTER_BITS'(k);
            if (!grant_valid && in_valid[cand]) begin
                grant_valid = 1'b1;
                grant_idx   = cand;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            io_req_valid <= 1'b0;
            rr_ptr       <= '0;
        end else if (out_free && grant_valid) begin
            io_req_valid <= 1'b1;
            rr_ptr       <= grant_idx + 1'b1;
        end else if (io_req_ready) begin
            io_req_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (out_free && grant_valid) begin
            io_req_data <= in_data[grant_idx];
            io_req_tag  <= {grant_idx, in_tag[grant_idx]};
        end
    end

    assign busy = io_req_valid;

endmodule

// File: io_req_if.sv
`timescale 1ns/1ps

interface io_req_if;

    logic                          valid;
    vx_config_pkg::word_t          data;
    vx_config_pkg::io_local_tag_t  tag;
    logic                          ready;

    modport unit (
        output valid, data, tag,
        input  ready
    );

    modport arbiter (
        input  valid, data, tag,
        output ready
    );

endinterface

// File: tb_input.txt
# name rw cluster addr data expected  (cluster in decimal, addr data expected in hex)
# rw 1 is a write, whose response is zero; expected is the returned word
scr_w_c0_r0   1 0 7c0 a5a50000 00000000
scr_w_c0_r3   1 0 7c3 12345678 00000000
scr_w_c1_r0   1 1 7c0 0000beef 00000000
scr_w_c3_r2   1 3 7c2 cafef00d 00000000
scr_r_c0_r3   0 0 7c3 00000000 12345678
scr_r_c1_r0   0 1 7c0 00000000 0000beef
scr_w_c0_r0b  1 0 7c0 0f0f0f0f 00000000
scr_r_c0_r0   0 0 7c0 00000000 0f0f0f0f
scr_r_c1_r0b  0 1 7c0 00000000 0000beef
scr_r_c3_r2   0 3 7c2 00000000 cafef00d
id_c2         0 2 7c8 00000000 00000002
id_c3         0 3 7c8 00000000 00000003
unmapped_c1   0 1 7d0 00000000 00000000
putc_c2_a     1 2 7c9 00000041 00000000
putc_c2_b     1 2 7c9 00000042 00000000
putc_c0_a     1 0 7c9 00000043 00000000
putc_c2_c     1 2 7c9 00000044 00000000
putc_cnt_c2   0 2 7c9 00000000 00000003
putc_cnt_c0   0 0 7c9 00000000 00000001
ebrk_w_c0     1 0 7ca 00000001 00000000
ebrk_w_c1     1 1 7ca 00000001 00000000
ebrk_w_c2     1 2 7ca 00000001 00000000
ebrk_r_c3     0 3 7ca 00000000 00000000
ebrk_w_c3     1 3 7ca 00000001 00000000
ebrk_r_c1     0 1 7ca 00000000 00000001

// File: tb_vortex_top.sv
`timescale 1ns/1ps

module tb_vortex_top;

    localparam int NUM_CLUSTERS  = vx_config_pkg::NUM_CLUSTERS_DEFAULT;
    localparam int CL_BITS       = $clog2(NUM_CLUSTERS);
    localparam int TAG_BITS      = CL_BITS + vx_config_pkg::IO_LOCAL_TAG_WIDTH;
    localparam int RESET_CYCLES  = 10;
    localparam int CYCLES_PER_OP = 64;

    logic                      clk;
    logic                      reset;
    logic                      csr_io_req_valid;
    logic [CL_BITS-1:0]        csr_io_req_coreid;
    vx_config_pkg::csr_addr_t  csr_io_req_addr;
    logic                      csr_io_req_rw;
    vx_config_pkg::word_t      csr_io_req_data;
    logic                      csr_io_req_ready;
    logic                      csr_io_rsp_valid;
    vx_config_pkg::word_t      csr_io_rsp_data;
    logic                      csr_io_rsp_ready;
    logic                      io_req_valid;
    vx_config_pkg::word_t      io_req_data;
    logic [TAG_BITS-1:0]       io_req_tag;
    logic                      io_req_ready;
    logic                      busy;
    logic                      ebreak;

    // Operations from the data file
    string                     op_name [$];
    logic                      op_rw [$];
    int                        op_cluster [$];
    vx_config_pkg::csr_addr_t  op_addr [$];
    vx_config_pkg::word_t      op_data [$];
    vx_config_pkg::word_t      op_expect [$];
    logic                      ops_loaded;

    // Console words still owed by each cluster
    vx_config_pkg::word_t      io_exp_data [NUM_CLUSTERS][$];
    logic [TAG_BITS-1:0]       io_exp_tag [NUM_CLUSTERS][$];
    int                        io_pending;
    int                        putc_sent [NUM_CLUSTERS];
    logic [NUM_CLUSTERS-1:0]   ebreak_model;
    logic [31:0]               lfsr_state;
    int                        error_count;

    vortex_top #(
        .NUM_CLUSTERS (NUM_CLUSTERS)
    ) dut_i (
        .clk               (clk),
        .reset             (reset),
        .csr_io_req_valid  (csr_io_req_valid),
        .csr_io_req_coreid (csr_io_req_coreid),
        .csr_io_req_addr   (csr_io_req_addr),
        .csr_io_req_rw     (csr_io_req_rw),
        .csr_io_req_data   (csr_io_req_data),
        .csr_io_req_ready  (csr_io_req_ready),
        .csr_io_rsp_valid  (csr_io_rsp_valid),
        .csr_io_rsp_data   (csr_io_rsp_data),
        .csr_io_rsp_ready  (csr_io_rsp_ready),
        .io_req_valid      (io_req_valid),
        .io_req_data       (io_req_data),
        .io_req_tag        (io_req_tag),
        .io_req_ready      (io_req_ready),
        .busy              (busy),
        .ebreak            (ebreak)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic stop_on_failure();
        $display("Errors found");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            error_count++;
            stop_on_failure();
        end
    endtask

    task automatic load_ops();
        int          fd;
        int          n;
        string       line;
        string       name;
        int          rw;
        int          cl;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] expv;
        fd = $fopen("tb_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open tb_input.txt");
            stop_on_failure();
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 0 && line[0] != "#") begin
                    if ($sscanf(line, "%s %d %d %h %h %h",
                                name, rw, cl, addr, data, expv) == 6) begin
                        op_name.push_back(name);
                        op_rw.push_back(rw[0]);
                        op_cluster.push_back(cl);
                        op_addr.push_back(addr[11:0]);
                        op_data.push_back(data);
                        op_expect.push_back(expv);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_op(input int idx);
        int                   cl;
        vx_config_pkg::word_t rsp;
        cl = op_cluster[idx];
        if (op_rw[idx] && op_addr[idx] == vx_csr_pkg::CSR_IO_PUTC) begin
            io_exp_data[cl].push_back(op_data[idx]);
            io_exp_tag[cl].push_back({CL_BITS'(cl), putc_sent[cl][3:0]});
            putc_sent[cl]++;
            io_pending++;
        end
        if (op_rw[idx] && op_addr[idx] == vx_csr_pkg::CSR_EBREAK) begin
            ebreak_model[cl] = op_data[idx][0];
        end
        @(negedge clk);
        csr_io_req_valid  = 1'b1;
        csr_io_req_coreid = CL_BITS'(cl);
        csr_io_req_addr   = op_addr[idx];
        csr_io_req_rw     = op_rw[idx];
        csr_io_req_data   = op_data[idx];
        @(posedge clk);
        while (!csr_io_req_ready) @(posedge clk);
        @(negedge clk);
        csr_io_req_valid = 1'b0;
        @(posedge clk);
        while (!(csr_io_rsp_valid && csr_io_rsp_ready)) @(posedge clk);
        rsp = csr_io_rsp_data;
        check_value(op_name[idx], op_expect[idx], rsp);
        // Router is out of idle while its response is pending
        check_value("busy_in_flight", 32'd1, 32'(busy));
        check_value("ebreak", 32'(&ebreak_model), 32'(ebreak));
    endtask

    // Random back-pressure on both host-side ready inputs
    initial begin
        lfsr_state       = 32'h1884;
        io_req_ready     = 1'b0;
        csr_io_rsp_ready = 1'b0;
        forever begin
            @(negedge clk);
            lfsr_state       = lfsr_step(lfsr_state);
            io_req_ready     = lfsr_state[0];
            lfsr_state       = lfsr_step(lfsr_state);
            csr_io_rsp_ready = lfsr_state[0];
        end
    end

    // I/O port model
    always @(posedge clk) begin
        int cl;
        if (!reset && io_req_valid && io_req_ready) begin
            cl = int'(io_req_tag[TAG_BITS-1:vx_config_pkg::IO_LOCAL_TAG_WIDTH]);
            if (io_exp_data[cl].size() == 0) begin
                $display("Console word %h from cluster %0d was not expected", io_req_data, cl);
                stop_on_failure();
            end else begin
                check_value("io_data", io_exp_data[cl].pop_front(), io_req_data);
                check_value("io_tag", 32'(io_exp_tag[cl].pop_front()), 32'(io_req_tag));
                io_pending--;
            end
        end
    end

    initial begin
        wait (ops_loaded);
        repeat (op_name.size() * CYCLES_PER_OP + RESET_CYCLES) @(posedge clk);
        $display("Timeout with %0d operations in the file", op_name.size());
        stop_on_failure();
    end

    initial begin
        reset             = 1'b1;
        csr_io_req_valid  = 1'b0;
        csr_io_req_coreid = '0;
        csr_io_req_addr   = '0;
        csr_io_req_rw     = 1'b0;
        csr_io_req_data   = '0;
        error_count       = 0;
        io_pending        = 0;
        ebreak_model      = '0;
        ops_loaded        = 1'b0;
        for (int c = 0; c < NUM_CLUSTERS; c++) begin
            putc_sent[c] = 0;
        end
        load_ops();
        ops_loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_value("req_ready_after_reset", 32'd1, 32'(csr_io_req_ready));
        check_value("ebreak_after_reset", 32'd0, 32'(ebreak));
        for (int i = 0; i < op_name.size(); i++) begin
            run_op(i);
        end
        // Let the I/O port drain
        while (io_pending != 0) @(negedge clk);
        @(negedge clk);
        check_value("busy_after_drain", 32'd0, 32'(busy));
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: vortex_top.sv
`timescale 1ns/1ps

module vortex_top #(
    parameter int NUM_CLUSTERS = vx_config_pkg::NUM_CLUSTERS_DEFAULT
) (
    input  logic                             clk,
    input  logic                             reset,

    input  logic                             csr_io_req_valid,
    input  logic [$clog2(NUM_CLUSTERS)-1:0]  csr_io_req_coreid,
    input  vx_config_pkg::csr_addr_t         csr_io_req_addr,
    input  logic                             csr_io_req_rw,
    input  vx_config_pkg::word_t             csr_io_req_data,
    output logic                             csr_io_req_ready,

    output logic                             csr_io_rsp_valid,
    output vx_config_pkg::word_t             csr_io_rsp_data,
    input  logic                             csr_io_rsp_ready,

    output logic                             io_req_valid,
    output vx_config_pkg::word_t             io_req_data,
    output logic [$clog2(NUM_CLUSTERS)+vx_config_pkg::IO_LOCAL_TAG_WIDTH-1:0] io_req_tag,
    input  logic                             io_req_ready,

    output logic                             busy,
    output logic                             ebreak
);

    logic                     router_busy;
    logic                     arb_busy;
    logic [NUM_CLUSTERS-1:0]  unit_busy;
    logic [NUM_CLUSTERS-1:0]  unit_ebreak;

    csr_bus_if csr_bus [NUM_CLUSTERS] ();
    io_req_if  io_bus  [NUM_CLUSTERS] ();

    csr_io_router #(
        .NUM_CLUSTERS (NUM_CLUSTERS)
    ) router_i (
        .clk               (clk),
        .reset             (reset),
        .csr_io_req_valid  (csr_io_req_valid),
        .csr_io_req_coreid (csr_io_req_coreid),
        .csr_io_req_addr   (csr_io_req_addr),
        .csr_io_req_rw     (csr_io_req_rw),
        .csr_io_req_data   (csr_io_req_data),
        .csr_io_req_ready  (csr_io_req_ready),
        .csr_io_rsp_valid  (csr_io_rsp_valid),
        .csr_io_rsp_data   (csr_io_rsp_data),
        .csr_io_rsp_ready  (csr_io_rsp_ready),
        .buses             (csr_bus),
        .busy              (router_busy)
    );

    for (genvar i = 0; i < NUM_CLUSTERS; i++) begin : g_cluster
        cluster_csr_unit #(
            .CLUSTER_ID (i)
        ) unit_i (
            .clk    (clk),
            .reset  (reset),
            .bus    (csr_bus[i]),
            .io     (io_bus[i]),
            .busy   (unit_busy[i]),
            .ebreak (unit_ebreak[i])
        );
    end

    io_arbiter #(
        .NUM_CLUSTERS (NUM_CLUSTERS)
    ) io_arb_i (
        .clk          (clk),
        .reset        (reset),
        .ins          (io_bus),
        .io_req_valid (io_req_valid),
        .io_req_data  (io_req_data),
        .io_req_tag   (io_req_tag),
        .io_req_ready (io_req_ready),
        .busy         (arb_busy)
    );

    assign busy   = router_busy || (|unit_busy) || arb_busy;
    assign ebreak = &unit_ebreak;

endmodule

// File: vortex_top_props.sv
`timescale 1ns/1ps

module vortex_top_props #(
    parameter int NUM_CLUSTERS = 4
) (
    input logic                  clk,
    input logic                  reset,
    input logic                  csr_io_rsp_valid,
    input vx_config_pkg::word_t  csr_io_rsp_data,
    input logic                  csr_io_rsp_ready,
    input logic                  io_req_valid,
    input vx_config_pkg::word_t  io_req_data,
    input logic [$clog2(NUM_CLUSTERS)+vx_config_pkg::IO_LOCAL_TAG_WIDTH-1:0] io_req_tag,
    input logic                  io_req_ready
);

    // Both valids come out of reset low
    assert property (@(posedge clk) reset |=> !csr_io_rsp_valid && !io_req_valid)
        else $error("valid output high in the cycle after reset");

    assert property (@(posedge clk) disable iff (reset)
        io_req_valid && !io_req_ready
        |=> io_req_valid && $stable(io_req_data) && $stable(io_req_tag))
        else $error("I/O request dropped or changed before io_req_ready");

    assert property (@(posedge clk) disable iff (reset)
        csr_io_rsp_valid && !csr_io_rsp_ready
        |=> csr_io_rsp_valid && $stable(csr_io_rsp_data))
        else $error("CSR response dropped or changed before csr_io_rsp_ready");

endmodule

bind vortex_top vortex_top_props #(
    .NUM_CLUSTERS (NUM_CLUSTERS)
) props_i (
    .clk              (clk),
    .reset            (reset),
    .csr_io_rsp_valid (csr_io_rsp_valid),
    .csr_io_rsp_data  (csr_io_rsp_data),
    .csr_io_rsp_ready (csr_io_rsp_ready),
    .io_req_valid     (io_req_valid),
    .io_req_data      (io_req_data),
    .io_req_tag       (io_req_tag),
    .io_req_ready     (io_req_ready)
);

// File: vx_config_pkg.sv
package vx_config_pkg;

    localparam int WORD_WIDTH          = 32;
    localparam int CSR_ADDR_WIDTH      = 12;
    localparam int IO_LOCAL_TAG_WIDTH  = 4;
    localparam int NUM_CLUSTERS_DEFAULT = 4;

    // Data word on the CSR and I/O paths
    typedef logic [WORD_WIDTH-1:0]         word_t;
    typedef logic [CSR_ADDR_WIDTH-1:0]     csr_addr_t;

    // Tag a cluster attaches to its console writes
    typedef logic [IO_LOCAL_TAG_WIDTH-1:0] io_local_tag_t;

endpackage

// File: vx_csr_pkg.sv
package vx_csr_pkg;

    // Four consecutive scratch registers start here
    localparam vx_config_pkg::csr_addr_t CSR_SCRATCH_BASE = 12'h7C0;

    // Read-only cluster index
    localparam vx_config_pkg::csr_addr_t CSR_CLUSTER_ID   = 12'h7C9 - 12'h001;

    // Write sends a console word, read returns the sent count
    localparam vx_config_pkg::csr_addr_t CSR_IO_PUTC      = 12'h7C9;

    // Bit 0 holds the ebreak flag
    localparam vx_config_pkg::csr_addr_t CSR_EBREAK       = 12'h7CA;

    localparam int NUM_SCRATCH = 4;

endpackage
